// File: src/scatter_pkg.sv
package scatter_pkg;

    // Wishbone word address and data widths
    localparam int WB_ADDR_W = 4;
    localparam int WB_DATA_W = 16;

    // Threshold magnitude width, element PRECISION must not exceed it
    localparam int CFG_W = 16;

    // Master to slave
    typedef struct packed {
        logic                 cyc;
        logic                 stb;
        logic                 we;
        logic [WB_ADDR_W-1:0] adr;
        logic [WB_DATA_W-1:0] dat;
    } wb_req_t;

    // Slave to master
    typedef struct packed {
        logic [WB_DATA_W-1:0] dat;
        logic                 ack;
    } wb_rsp_t;

    // Register block to datapath
    typedef struct packed {
        logic [CFG_W-1:0] threshold;
        logic [7:0]       slot_limit;
    } scatter_cfg_t;

    // Datapath to register block, single-cycle pulses
    typedef struct packed {
        logic vec_done;
        logic dropped;
    } scatter_stat_t;

    typedef enum logic [WB_ADDR_W-1:0] {
        REG_THRESHOLD  = 4'd0,
        REG_SLOT_LIMIT = 4'd1,
        REG_VEC_COUNT  = 4'd2,
        REG_DROP_COUNT = 4'd3
    } reg_addr_e;

endpackage

// File: src/priority_encoder.sv
module priority_encoder #(
    parameter int NUM_INPUT_CHANNELS = 8,
    parameter int NO_INDICIES        = 2
) (
    // Only samples the grant-count check
    input  logic                          clk,
    input  logic [NUM_INPUT_CHANNELS-1:0] input_channels,
    input  logic [7:0]                    slot_limit,
    output logic [NUM_INPUT_CHANNELS-1:0] mask,
    output logic                          overflow
);

    localparam int CNT_W = $clog2(NUM_INPUT_CHANNELS + 1) + 1;

    logic [CNT_W-1:0] grant_cnt;

    // Lowest index wins, stop once slot_limit grants are given
    always_comb begin
        logic [CNT_W-1:0] cnt;
        logic             left;
        cnt  = '0;
        left = 1'b0;
        mask = '0;
        for (int i = 0; i < NUM_INPUT_CHANNELS; i++) begin
            if (input_channels[i]) begin
                if (8'(cnt) < slot_limit) begin
                    mask[i] = 1'b1;
                    cnt     = cnt + 1'b1;
                end else begin
                    left = 1'b1;
                end
            end
        end
        grant_cnt = cnt;
        overflow  = left;
    end

    // Relies on the register block clamping slot_limit
    grants_within_slots: assert property (
        @(posedge clk) grant_cnt <= CNT_W'(NO_INDICIES)
    );

endmodule

// File: src/array_zero_mask.sv
module array_zero_mask #(
    parameter int NUM_INPUTS = 8,
    parameter int PRECISION  = 8
) (
    input  logic [NUM_INPUTS-1:0][PRECISION-1:0] data,
    input  logic [NUM_INPUTS-1:0]                mask,
    output logic [NUM_INPUTS-1:0][PRECISION-1:0] data_out_0,
    output logic [NUM_INPUTS-1:0][PRECISION-1:0] data_out_1
);

    // Masked-in copy on port 0, masked-out copy on port 1
    for (genvar i = 0; i < NUM_INPUTS; i++) begin : g_elem
        assign data_out_0[i] = mask[i] ? data[i] : '0;
        assign data_out_1[i] = mask[i] ? '0 : data[i];
    end

endmodule

// File: src/scatter_cfg_regs.sv
module scatter_cfg_regs import scatter_pkg::*; #(
    parameter int HIGH_SLOTS      = 2,
    parameter int RESET_THRESHOLD = 6
) (
    input  logic          clk,
    input  logic          arst_n,
    input  wb_req_t       wb_req,
    output wb_rsp_t       wb_rsp,
    output scatter_cfg_t  cfg,
    input  scatter_stat_t stat
);

    logic                 ack_q;
    logic [WB_DATA_W-1:0] rdata_q;
    logic [WB_DATA_W-1:0] rd_mux;
    logic                 access;
    logic                 wr_en;
    logic [CFG_W-1:0]     threshold_q;
    logic [7:0]           slot_limit_q;
    logic [15:0]          vec_cnt_q;
    logic [15:0]          drop_cnt_q;
    logic                 cnt_clear;

    // New access only when the previous one has been acked
    assign access    = wb_req.cyc & wb_req.stb & ~ack_q;
    assign wr_en     = access & wb_req.we;
    assign cnt_clear = wr_en && (reg_addr_e'(wb_req.adr) == REG_DROP_COUNT);

    always_comb begin
        case (reg_addr_e'(wb_req.adr))
            REG_THRESHOLD:  rd_mux = WB_DATA_W'(threshold_q);
            REG_SLOT_LIMIT: rd_mux = WB_DATA_W'(slot_limit_q);
            REG_VEC_COUNT:  rd_mux = vec_cnt_q;
            REG_DROP_COUNT: rd_mux = drop_cnt_q;
            default:        rd_mux = '0;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= access;
        end
    end

    // Read data lands together with ack
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rdata_q <= '0;
        end else if (access) begin
            rdata_q <= wb_req.we ? '0 : rd_mux;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            threshold_q  <= CFG_W'(RESET_THRESHOLD);
            slot_limit_q <= 8'(HIGH_SLOTS);
        end else if (wr_en) begin
            case (reg_addr_e'(wb_req.adr))
                REG_THRESHOLD: threshold_q <= wb_req.dat[CFG_W-1:0];
                REG_SLOT_LIMIT: begin
                    // Clamp to the number of high-precision slots
                    if (wb_req.dat > WB_DATA_W'(HIGH_SLOTS))
                        slot_limit_q <= 8'(HIGH_SLOTS);
                    else
                        slot_limit_q <= wb_req.dat[7:0];
                end
                default: ;
            endcase
        end
    end

    // Saturating event counters
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            vec_cnt_q  <= '0;
            drop_cnt_q <= '0;
        end else if (cnt_clear) begin
            vec_cnt_q  <= '0;
            drop_cnt_q <= '0;
        end else begin
            if (stat.vec_done && (vec_cnt_q != '1))
                vec_cnt_q <= vec_cnt_q + 16'd1;
            if (stat.dropped && (drop_cnt_q != '1))
                drop_cnt_q <= drop_cnt_q + 16'd1;
        end
    end

    assign wb_rsp.dat     = rdata_q;
    assign wb_rsp.ack     = ack_q;
    assign cfg.threshold  = threshold_q;
    assign cfg.slot_limit = slot_limit_q;

    // Single-cycle ack even while the master keeps stb asserted
    ack_single_cycle: assert property (
        @(posedge clk) disable iff (!arst_n)
        (wb_rsp.ack && wb_req.stb) |=> !wb_rsp.ack
    );

endmodule

// File: src/scatter_threshold.sv
module scatter_threshold import scatter_pkg::*; #(
    parameter int PRECISION       = 8,
    parameter int TENSOR_SIZE_DIM = 8,
    parameter int HIGH_SLOTS      = 2
) (
    input  logic                                      clk,
    input  logic                                      arst_n,
    input  scatter_cfg_t                              cfg,
    input  logic                                      in_valid,
    input  logic [TENSOR_SIZE_DIM-1:0][PRECISION-1:0] in_data,
    output logic                                      out_valid,
    output logic [TENSOR_SIZE_DIM-1:0][PRECISION-1:0] out_high,
    output logic [TENSOR_SIZE_DIM-1:0][PRECISION-1:0] out_low,
    output scatter_stat_t                             stat
);

    // Two spare bits keep +/- threshold and the sign-extended element in range
    localparam int CMP_W = CFG_W + 2;

    logic                                      valid_q;
    logic [TENSOR_SIZE_DIM-1:0][PRECISION-1:0] data_q;
    scatter_cfg_t                              cfg_q;
    logic signed [CMP_W-1:0]                   thr_pos;
    logic [TENSOR_SIZE_DIM-1:0]                req;
    logic [TENSOR_SIZE_DIM-1:0]                grant_mask;
    logic                                      overflow;
    logic [TENSOR_SIZE_DIM-1:0][PRECISION-1:0] high_d;
    logic [TENSOR_SIZE_DIM-1:0][PRECISION-1:0] low_d;
    logic [TENSOR_SIZE_DIM-1:0]                high_nz;
    logic [TENSOR_SIZE_DIM-1:0]                low_nz;

    // Stage 1, vector and config captured on the same edge
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= 1'b0;
            cfg_q   <= '0;
            data_q  <= '0;
        end else begin
            valid_q <= in_valid;
            cfg_q   <= cfg;
            if (in_valid)
                data_q <= in_data;
        end
    end

    assign thr_pos = signed'({2'b00, cfg_q.threshold});

    // Outlier when strictly outside [-threshold, +threshold]
    for (genvar i = 0; i < TENSOR_SIZE_DIM; i++) begin : g_req
        logic signed [CMP_W-1:0] elem;
        assign elem   = CMP_W'(signed'(data_q[i]));
        assign req[i] = (elem > thr_pos) || (elem < -thr_pos);
    end

    priority_encoder #(
        .NUM_INPUT_CHANNELS (TENSOR_SIZE_DIM),
        .NO_INDICIES        (HIGH_SLOTS)
    ) encoder_i (
        .clk            (clk),
        .input_channels (req),
        .slot_limit     (cfg_q.slot_limit),
        .mask           (grant_mask),
        .overflow       (overflow)
    );

    array_zero_mask #(
        .NUM_INPUTS (TENSOR_SIZE_DIM),
        .PRECISION  (PRECISION)
    ) masker_i (
        .data       (data_q),
        .mask       (grant_mask),
        .data_out_0 (high_d),
        .data_out_1 (low_d)
    );

    // Stage 2, outputs hold between vectors
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid     <= 1'b0;
            out_high      <= '0;
            out_low       <= '0;
            stat.vec_done <= 1'b0;
            stat.dropped  <= 1'b0;
        end else begin
            out_valid     <= valid_q;
            stat.vec_done <= valid_q;
            stat.dropped  <= valid_q & overflow;
            if (valid_q) begin
                out_high <= high_d;
                out_low  <= low_d;
            end
        end
    end

    for (genvar i = 0; i < TENSOR_SIZE_DIM; i++) begin : g_nz
        assign high_nz[i] = |out_high[i];
        assign low_nz[i]  = |out_low[i];
    end

    // An element goes to exactly one copy
    split_exclusive: assert property (
        @(posedge clk) disable iff (!arst_n)
        (high_nz & low_nz) == '0
    );

endmodule

// File: src/scatter_top.sv
module scatter_top import scatter_pkg::*; #(
    parameter int PRECISION       = 8,
    parameter int TENSOR_SIZE_DIM = 8,
    parameter int HIGH_SLOTS      = 2,
    parameter int RESET_THRESHOLD = 6
) (
    input  logic                                      clk,
    input  logic                                      arst_n,
    input  wb_req_t                                   wb_req,
    output wb_rsp_t                                   wb_rsp,
    input  logic                                      in_valid,
    input  logic [TENSOR_SIZE_DIM-1:0][PRECISION-1:0] in_data,
    output logic                                      out_valid,
    output logic [TENSOR_SIZE_DIM-1:0][PRECISION-1:0] out_high,
    output logic [TENSOR_SIZE_DIM-1:0][PRECISION-1:0] out_low
);

    scatter_cfg_t  cfg;
    scatter_stat_t stat;

    scatter_cfg_regs #(
        .HIGH_SLOTS      (HIGH_SLOTS),
        .RESET_THRESHOLD (RESET_THRESHOLD)
    ) cfg_regs_i (
        .clk    (clk),
        .arst_n (arst_n),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp),
        .cfg    (cfg),
        .stat   (stat)
    );

    // Outlier split datapath
    scatter_threshold #(
        .PRECISION       (PRECISION),
        .TENSOR_SIZE_DIM (TENSOR_SIZE_DIM),
        .HIGH_SLOTS      (HIGH_SLOTS)
    ) datapath_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .cfg       (cfg),
        .in_valid  (in_valid),
        .in_data   (in_data),
        .out_valid (out_valid),
        .out_high  (out_high),
        .out_low   (out_low),
        .stat      (stat)
    );

endmodule

// File: tests/tb_scatter.sv
module tb_scatter import scatter_pkg::*; ();

    localparam int PREC    = 8;
    localparam int DIM     = 8;
    localparam int SLOTS   = 2;
    localparam int RST_THR = 6;
    localparam int TIMEOUT = 50;

    typedef logic [DIM-1:0][PREC-1:0] vec_t;

    logic    clk;
    logic    arst_n;
    wb_req_t wb_req;
    wb_rsp_t wb_rsp;
    logic    in_valid;
    vec_t    in_data;
    logic    out_valid;
    vec_t    out_high;
    vec_t    out_low;

    int          errors;
    int          tests;
    logic [31:0] rng;
    int          cur_thr;
    int          cur_slots;
    int          total_vecs;
    vec_t        last_hi;
    vec_t        last_lo;
    vec_t        stim_q[$];

    scatter_top #(
        .PRECISION       (PREC),
        .TENSOR_SIZE_DIM (DIM),
        .HIGH_SLOTS      (SLOTS),
        .RESET_THRESHOLD (RST_THR)
    ) scatter_top_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .wb_req    (wb_req),
        .wb_rsp    (wb_rsp),
        .in_valid  (in_valid),
        .in_data   (in_data),
        .out_valid (out_valid),
        .out_high  (out_high),
        .out_low   (out_low)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    function automatic vec_t make_vec(input int e[DIM]);
        vec_t v;
        for (int i = 0; i < DIM; i++)
            v[i] = PREC'(e[i]);
        return v;
    endfunction

    // Reference split with strict outliers granted lowest index first up to the slot limit
    function automatic void split_model(input vec_t vec, input int thr, input int slots,
                                        output vec_t hi, output vec_t lo);
        int granted;
        int v;
        hi      = '0;
        lo      = '0;
        granted = 0;
        for (int i = 0; i < DIM; i++) begin
            v = $signed(vec[i]);
            if ((v > thr || v < -thr) && granted < slots) begin
                hi[i]   = vec[i];
                granted = granted + 1;
            end else begin
                lo[i] = vec[i];
            end
        end
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("ERR time=%0t %s got=%h exp=%h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int err_start);
        tests++;
        $display("%s done, %0d errors", name, errors - err_start);
    endtask

    task automatic write_reg(input logic [3:0] adr, input logic [15:0] dat);
        wb_req_t req;
        int      n;
        req     = '0;
        req.cyc = 1'b1;
        req.stb = 1'b1;
        req.we  = 1'b1;
        req.adr = adr;
        req.dat = dat;
        @(posedge clk);
        wb_req <= req;
        n = 0;
        @(negedge clk);
        while (!wb_rsp.ack && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!wb_rsp.ack) begin
            $display("Wishbone write to address %0d was never acknowledged", adr);
            errors++;
        end
        @(posedge clk);
        wb_req <= '0;
    endtask

    task automatic read_reg(input logic [3:0] adr, output logic [15:0] dat);
        wb_req_t req;
        int      n;
        req     = '0;
        req.cyc = 1'b1;
        req.stb = 1'b1;
        req.adr = adr;
        dat     = '0;
        @(posedge clk);
        wb_req <= req;
        n = 0;
        @(negedge clk);
        while (!wb_rsp.ack && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (wb_rsp.ack) begin
            dat = wb_rsp.dat;
        end else begin
            $display("Wishbone read from address %0d was never acknowledged", adr);
            errors++;
        end
        @(posedge clk);
        wb_req <= '0;
    endtask

    task automatic set_config(input int thr, input int slots);
        write_reg(REG_THRESHOLD, 16'(thr));
        write_reg(REG_SLOT_LIMIT, 16'(slots));
        cur_thr   = thr;
        cur_slots = (slots > SLOTS) ? SLOTS : slots;
    endtask

    // Vectors go in on consecutive cycles and come back in order
    task automatic send_vectors();
        vec_t exp_hi[$];
        vec_t exp_lo[$];
        vec_t hi;
        vec_t lo;
        int   count;
        int   sent;
        int   got;
        int   cycles;
        count = stim_q.size();
        foreach (stim_q[i]) begin
            split_model(stim_q[i], cur_thr, cur_slots, hi, lo);
            exp_hi.push_back(hi);
            exp_lo.push_back(lo);
        end
        sent   = 0;
        got    = 0;
        cycles = 0;
        while (got < count && cycles < count + TIMEOUT) begin
            @(posedge clk);
            if (sent < count) begin
                in_valid <= 1'b1;
                in_data  <= stim_q[sent];
                sent++;
            end else begin
                in_valid <= 1'b0;
            end
            @(negedge clk);
            if (out_valid) begin
                check_value("out_high", out_high, exp_hi[got]);
                check_value("out_low", out_low, exp_lo[got]);
                // Two cycles from the driving edge
                check_value("latency", 64'(cycles), 64'(got + 2));
                last_hi = out_high;
                last_lo = out_low;
                got++;
            end
            cycles++;
        end
        if (got < count) begin
            $display("Stream timed out with %0d of %0d vectors returned", got, count);
            errors++;
        end
        total_vecs += count;
        stim_q.delete();
    endtask

    task automatic reset_defaults();
        logic [15:0] rd;
        int          err_start;
        err_start = errors;
        // Outputs idle straight out of reset
        @(negedge clk);
        check_value("out_valid", 64'(out_valid), 64'd0);
        check_value("out_high", out_high, 64'd0);
        check_value("out_low", out_low, 64'd0);
        check_value("wb_rsp", 64'(wb_rsp), 64'd0);
        read_reg(REG_THRESHOLD, rd);
        check_value("threshold", 64'(rd), 64'(RST_THR));
        read_reg(REG_SLOT_LIMIT, rd);
        check_value("slot_limit", 64'(rd), 64'(SLOTS));
        read_reg(REG_VEC_COUNT, rd);
        check_value("vec_count", 64'(rd), 64'd0);
        read_reg(REG_DROP_COUNT, rd);
        check_value("drop_count", 64'(rd), 64'd0);
        write_reg(REG_SLOT_LIMIT, 16'd1);
        read_reg(REG_SLOT_LIMIT, rd);
        check_value("slot_limit written", 64'(rd), 64'd1);
        set_config(RST_THR, 9);
        read_reg(REG_SLOT_LIMIT, rd);
        check_value("slot_limit clamped", 64'(rd), 64'(SLOTS));
        report_test("reset_defaults", err_start);
    endtask

    task automatic single_outlier();
        int err_start;
        err_start = errors;
        stim_q.push_back(make_vec('{5, -6, 0, 50, 6, -3, 2, 1}));
        send_vectors();
        check_value("high copy", last_hi, make_vec('{0, 0, 0, 50, 0, 0, 0, 0}));
        check_value("low copy", last_lo, make_vec('{5, -6, 0, 0, 6, -3, 2, 1}));
        report_test("single_outlier", err_start);
    endtask

    task automatic slot_overflow();
        logic [15:0] rd;
        int          err_start;
        err_start = errors;
        // Five outliers while the +/-6 entries sit exactly on the threshold
        stim_q.push_back(make_vec('{6, 30, -6, -40, 7, -7, 100, 2}));
        send_vectors();
        check_value("high copy", last_hi, make_vec('{0, 30, 0, -40, 0, 0, 0, 0}));
        check_value("low copy", last_lo, make_vec('{6, 0, -6, 0, 7, -7, 100, 2}));
        read_reg(REG_DROP_COUNT, rd);
        check_value("drop_count", 64'(rd), 64'd1);
        report_test("slot_overflow", err_start);
    endtask

    task automatic config_change();
        logic [31:0] r0;
        logic [31:0] r1;
        vec_t        v;
        int          err_start;
        err_start = errors;
        set_config(20, 1);
        stim_q.push_back(make_vec('{21, -21, 20, -20, 0, 25, 3, -30}));
        send_vectors();
        check_value("high copy", last_hi, make_vec('{21, 0, 0, 0, 0, 0, 0, 0}));
        check_value("low copy", last_lo, make_vec('{0, -21, 20, -20, 0, 25, 3, -30}));
        for (int i = 0; i < 3; i++) begin
            r0 = next_rand();
            r1 = next_rand();
            stim_q.push_back({r1, r0});
        end
        send_vectors();
        // With no slots left everything stays in the low copy
        set_config(20, 0);
        v = make_vec('{-100, 50, 1, 2, 3, 4, 5, 90});
        stim_q.push_back(v);
        send_vectors();
        check_value("high copy", last_hi, '0);
        check_value("low copy", last_lo, v);
        report_test("config_change", err_start);
    endtask

    task automatic back_to_back();
        logic [31:0] r0;
        logic [31:0] r1;
        logic [15:0] rd;
        int          err_start;
        err_start = errors;
        set_config(60, 2);
        for (int i = 0; i < 40; i++) begin
            r0 = next_rand();
            r1 = next_rand();
            stim_q.push_back({r1, r0});
        end
        send_vectors();
        read_reg(REG_VEC_COUNT, rd);
        check_value("vec_count", 64'(rd), 64'(total_vecs));
        write_reg(REG_DROP_COUNT, 16'd0);
        read_reg(REG_VEC_COUNT, rd);
        check_value("vec_count cleared", 64'(rd), 64'd0);
        read_reg(REG_DROP_COUNT, rd);
        check_value("drop_count cleared", 64'(rd), 64'd0);
        report_test("back_to_back", err_start);
    endtask

    initial begin
        errors     = 0;
        tests      = 0;
        rng        = 32'd88;
        cur_thr    = RST_THR;
        cur_slots  = SLOTS;
        total_vecs = 0;
        last_hi    = '0;
        last_lo    = '0;
        arst_n     = 1'b0;
        wb_req     = '0;
        in_valid   = 1'b0;
        in_data    = '0;
        repeat (8) @(posedge clk);
        arst_n <= 1'b1;
        @(posedge clk);
        reset_defaults();
        single_outlier();
        slot_overflow();
        config_change();
        back_to_back();
        $display("tests run: %0d, errors: %0d", tests, errors);
        if (errors == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule

// File: vlog.f
src/scatter_pkg.sv
src/priority_encoder.sv
src/array_zero_mask.sv
src/scatter_cfg_regs.sv
src/scatter_threshold.sv
src/scatter_top.sv
tests/tb_scatter.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the scatter testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1
mkdir -p build

verilator --binary --timing --assert -f vlog.f --top-module tb_scatter \
    -Mdir build -o sim_scatter \
    && ./build/sim_scatter > build/sim.log 2>&1 \
    || { cat build/sim.log 2>/dev/null; echo "Build or run failed"; exit 1; }

cat build/sim.log

grep -q "RESULT: PASS" build/sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
